//--- build.f
+incdir+include
verilog/obi_pkg.sv
verilog/reg_pkg.sv
verilog/slow_memory.sv
verilog/obi_arbiter.sv
verilog/memcopy_periph.sv
verilog/ext_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_ext_subsystem.sv

//--- include/ext_macros.svh
/*
 * Size and timing constants for the external-device subsystem.
 * Include wherever bus widths, memory depth or memory latency are needed.
 */
`ifndef EXT_MACROS_SVH
`define EXT_MACROS_SVH

// Byte address width, same on the memory bus and for copier pointers
`define EXT_ADDR_W 32

// Data width of every bus word
`define EXT_DATA_W 32

// Slow memory depth in words, indexed by address bits 8:2
`define EXT_MEM_WORDS 128

// Cycles from the grant cycle to the matching rvalid
`define EXT_MEM_LATENCY 3

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it into sim.log, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_ext_subsystem -o tb_ext_subsystem \
  && ./obj_dir/tb_ext_subsystem > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }
[ -f sim.log ] && cat sim.log && ! grep -q "RESULT: FAIL" sim.log

//--- testbench/tb_clock_gen.sv
/*
 * Testbench clock and a synchronous reset pulse at the start of the run.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset low for RST_CYCLES rising edges, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_ext_subsystem.sv
/*
 * Testbench for ext_subsystem. Host traffic, register access and copies
 * with and without host contention, all checked by assertions.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_macros.svh"

module tb_ext_subsystem;

  localparam int CLK_PERIOD    = 8;
  localparam int HOST_WORDS    = 16;
  localparam int CONTEND_WORDS = 8;
  localparam int MAX_COPY      = 16;
  localparam int WAIT_LIMIT    = 200;
  // Host, register and copier transactions over all tests
  localparam int PLANNED_TXNS  = 2 * HOST_WORDS + 2 * CONTEND_WORDS + 10 * MAX_COPY + 40;

  logic               clk;
  logic               rst_n;
  obi_pkg::obi_req_t  host_req;
  obi_pkg::obi_resp_t host_resp;
  reg_pkg::reg_req_t  reg_req;
  reg_pkg::reg_rsp_t  reg_rsp;
  logic               copy_intr;

  logic [`EXT_DATA_W-1:0] mem_model [`EXT_MEM_WORDS];
  int   mismatch_count = 0;
  int   protocol_count = 0;
  int   intr_count     = 0;
  int   expected_intr  = 0;
  int   host_lat       = 0;
  logic host_pending   = 1'b0;
  logic copy_pending   = 1'b0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(4)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ext_subsystem u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .host_req_i  (host_req),
    .host_resp_o (host_resp),
    .reg_req_i   (reg_req),
    .reg_rsp_o   (reg_rsp),
    .copy_intr_o (copy_intr)
  );

  intr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                                   copy_intr |=> !copy_intr)
    else begin
      $display("Copy interrupt stayed high longer than one cycle at %0t", $time);
      protocol_count++;
    end

  ready_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
                                     reg_req.valid |-> reg_rsp.ready)
    else begin
      $display("Register request at %0t was not answered with ready", $time);
      protocol_count++;
    end

  // Bus monitor, mid-cycle where the outputs have settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (host_pending) host_lat++;
      if (host_resp.rvalid) begin
        assert (host_pending) else begin
          $display("Host saw rvalid at %0t without a preceding gnt", $time);
          protocol_count++;
        end
        assert (host_lat == `EXT_MEM_LATENCY) else begin
          $display("MISMATCH t=%0t host_resp_o.rvalid latency expected %0d actual %0d",
                   $time, `EXT_MEM_LATENCY, host_lat);
          mismatch_count++;
        end
        host_pending = 1'b0;
      end
      if (host_resp.gnt) begin
        host_pending = 1'b1;
        host_lat     = 0;
      end
      if (u_dut.copy_resp.rvalid) begin
        assert (copy_pending) else begin
          $display("Copier saw rvalid at %0t without a preceding gnt", $time);
          protocol_count++;
        end
        copy_pending = 1'b0;
      end
      if (u_dut.copy_resp.gnt) copy_pending = 1'b1;
      if (copy_intr) intr_count++;
    end
  end

  function automatic int word_index(input logic [`EXT_ADDR_W-1:0] addr);
    return int'(addr[8:2]);
  endfunction

  // One host transaction, request held until gnt, then wait for rvalid
  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited   = 0;
    host_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    do begin
      @(negedge clk);
      waited++;
    end while (!host_resp.gnt && waited < WAIT_LIMIT);
    if (!host_resp.gnt) begin
      $display("Host request to 0x%08h was never granted", addr);
      protocol_count++;
    end
    @(posedge clk);
    #1;
    host_req = '0;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!host_resp.rvalid && waited < WAIT_LIMIT);
    if (!host_resp.rvalid) begin
      $display("Host access to 0x%08h never got rvalid", addr);
      protocol_count++;
    end
    rdata = host_resp.rdata;
    @(posedge clk);
    #1;
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    host_access(1'b1, addr, data, unused);
    mem_model[word_index(addr)] = data;
  endtask

  task automatic host_check(input logic [31:0] addr);
    logic [31:0] rd;
    host_access(1'b0, addr, '0, rd);
    assert (rd === mem_model[word_index(addr)]) else begin
      $display("MISMATCH t=%0t host_resp_o.rdata @0x%08h expected 0x%08h actual 0x%08h",
               $time, addr, mem_model[word_index(addr)], rd);
      mismatch_count++;
    end
  endtask

  // Single register access; read data only checked on a legal read
  task automatic reg_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_rdata, input logic exp_error);
    int waited;
    waited  = 0;
    reg_req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
    do begin
      @(negedge clk);
      waited++;
    end while (!reg_rsp.ready && waited < WAIT_LIMIT);
    assert (reg_rsp.error === exp_error) else begin
      $display("MISMATCH t=%0t reg_rsp_o.error @0x%02h expected %0b actual %0b",
               $time, addr, exp_error, reg_rsp.error);
      mismatch_count++;
    end
    if (!write && !exp_error) begin
      assert (reg_rsp.rdata === exp_rdata) else begin
        $display("MISMATCH t=%0t reg_rsp_o.rdata @0x%02h expected 0x%08h actual 0x%08h",
                 $time, addr, exp_rdata, reg_rsp.rdata);
        mismatch_count++;
      end
    end
    @(posedge clk);
    #1;
    reg_req = '0;
  endtask

  task automatic run_copy(input logic [31:0] src, input logic [31:0] dst, input int n,
                          input bit contend);
    int waited;
    waited = 0;
    reg_access(1'b1, reg_pkg::REG_SRC, src, '0, 1'b0);
    reg_access(1'b1, reg_pkg::REG_DST, dst, '0, 1'b0);
    reg_access(1'b1, reg_pkg::REG_SIZE, n, '0, 1'b0);
    reg_access(1'b1, reg_pkg::REG_CTRL, 32'h1, '0, 1'b0);
    expected_intr++;
    // Busy with done cleared right after the start
    reg_access(1'b0, reg_pkg::REG_STATUS, '0, 32'h1, 1'b0);
    // Second start while busy, no extra pulse allowed
    if (n > 0) reg_access(1'b1, reg_pkg::REG_CTRL, 32'h1, '0, 1'b0);
    if (contend) begin
      for (int i = 0; i < CONTEND_WORDS; i++) host_write(32'h100 + 4 * i, $urandom());
      for (int i = 0; i < CONTEND_WORDS; i++) host_check(32'h100 + 4 * i);
    end
    while (intr_count < expected_intr && waited < WAIT_LIMIT * MAX_COPY) begin
      @(posedge clk);
      waited++;
    end
    if (intr_count < expected_intr) begin
      $display("Copy of %0d words never raised its interrupt", n);
      protocol_count++;
    end
    @(posedge clk);
    #1;
    reg_access(1'b0, reg_pkg::REG_STATUS, '0, 32'h2, 1'b0);
    for (int i = 0; i < n; i++) mem_model[word_index(dst) + i] = mem_model[word_index(src) + i];
    for (int i = 0; i < n; i++) begin
      host_check(dst + 4 * i);
      host_check(src + 4 * i);
    end
  endtask

  initial begin
    logic [31:0] addrs [HOST_WORDS];
    logic [31:0] cfg [3];
    int          n;
    void'($urandom(17));
    host_req = '0;
    reg_req  = '0;
    @(posedge rst_n);
    @(negedge clk);
    assert (!host_resp.gnt && !host_resp.rvalid && !copy_intr && !reg_rsp.ready &&
            !u_dut.copy_req.req) else begin
      $display("Outputs were not inactive after reset");
      protocol_count++;
    end
    @(posedge clk);
    #1;

    // Random words in the upper quarter, written then read back
    foreach (addrs[i]) begin
      addrs[i] = 32'h180 + 4 * $urandom_range(0, 31);
      host_write(addrs[i], $urandom());
    end
    foreach (addrs[i]) host_check(addrs[i]);

    // SRC, DST and SIZE sit at offsets 0, 4 and 8
    reg_access(1'b0, reg_pkg::REG_STATUS, '0, '0, 1'b0);
    foreach (cfg[i]) begin
      cfg[i] = $urandom();
      reg_access(1'b1, 8'(4 * i), cfg[i], '0, 1'b0);
    end
    foreach (cfg[i]) reg_access(1'b0, 8'(4 * i), '0, cfg[i], 1'b0);
    reg_access(1'b1, 8'h14, 32'hFFFF_FFFF, '0, 1'b1);
    reg_access(1'b0, 8'h14, '0, '0, 1'b1);
    reg_access(1'b1, reg_pkg::REG_STATUS, 32'h3, '0, 1'b1);
    reg_access(1'b0, reg_pkg::REG_STATUS, '0, '0, 1'b0);
    foreach (cfg[i]) reg_access(1'b0, 8'(4 * i), '0, cfg[i], 1'b0);

    for (int i = 0; i < MAX_COPY; i++) host_write(4 * i, $urandom());
    n = $urandom_range(1, MAX_COPY);
    run_copy(32'h000, 32'h080, n, 1'b0);
    // Known words at the empty copy's destination, expected to survive it
    for (int i = 0; i < MAX_COPY; i++) host_write(32'h0C0 + 4 * i, $urandom());
    run_copy(32'h000, 32'h0C0, 0, 1'b0);
    for (int i = 0; i < MAX_COPY; i++) host_check(32'h0C0 + 4 * i);

    // Full-length copy so that host traffic overlaps it
    for (int i = 0; i < MAX_COPY; i++) host_write(4 * i, $urandom());
    run_copy(32'h000, 32'h080, MAX_COPY, 1'b1);

    repeat (10) @(posedge clk);
    assert (intr_count == expected_intr) else begin
      $display("MISMATCH t=%0t copy_intr_o pulses expected %0d actual %0d",
               $time, expected_intr, intr_count);
      mismatch_count++;
    end
    $display("Closing counts: %0d mismatches, %0d protocol errors",
             mismatch_count, protocol_count);
    if (mismatch_count == 0 && protocol_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog, 200 cycles per planned transaction
  initial begin
    #(PLANNED_TXNS * 200 * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish in time");
    $display("Closing counts: %0d mismatches, %0d protocol errors",
             mismatch_count, protocol_count);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ext_subsystem.sv
/*
 * External-device subsystem top. The host port and the copier share
 * the slow memory through the arbiter; the copier is set up over reg_req_i.
 */
`timescale 1ns/1ps
`default_nettype none

module ext_subsystem (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  host_req_i,
  output obi_pkg::obi_resp_t host_resp_o,
  input  reg_pkg::reg_req_t  reg_req_i,
  output reg_pkg::reg_rsp_t  reg_rsp_o,
  output logic               copy_intr_o
);

  // Copier master port
  obi_pkg::obi_req_t  copy_req;
  obi_pkg::obi_resp_t copy_resp;

  // Shared memory port
  obi_pkg::obi_req_t  mem_req;
  obi_pkg::obi_resp_t mem_resp;

  memcopy_periph u_memcopy (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (reg_req_i),
    .reg_rsp_o     (reg_rsp_o),
    .master_req_o  (copy_req),
    .master_resp_i (copy_resp),
    .copy_intr_o   (copy_intr_o)
  );

  obi_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .host_req_i  (host_req_i),
    .host_resp_o (host_resp_o),
    .copy_req_i  (copy_req),
    .copy_resp_o (copy_resp),
    .mem_req_o   (mem_req),
    .mem_resp_i  (mem_resp)
  );

  slow_memory u_memory (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_req_i  (mem_req),
    .mem_resp_o (mem_resp)
  );

endmodule

`default_nettype wire

//--- verilog/memcopy_periph.sv
/*
 * Memory-copy peripheral. SRC, DST and SIZE are set over the register bus,
 * a CTRL write starts the copy and copy_intr_o pulses once at the end.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_macros.svh"

module memcopy_periph (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  reg_pkg::reg_req_t  reg_req_i,
  output reg_pkg::reg_rsp_t  reg_rsp_o,
  output obi_pkg::obi_req_t  master_req_o,
  input  obi_pkg::obi_resp_t master_resp_i,
  output logic               copy_intr_o
);

  logic [`EXT_ADDR_W-1:0] src_q;
  logic [`EXT_ADDR_W-1:0] dst_q;
  logic [`EXT_DATA_W-1:0] size_q;
  logic                   done_q;
  logic                   intr_q;
  logic                   busy;
  reg_pkg::copy_state_e   state_q;
  logic [`EXT_DATA_W-1:0] idx_q;
  logic [`EXT_DATA_W-1:0] data_q;
  logic [`EXT_ADDR_W-1:0] word_off;
  logic                   reg_hit;
  logic                   wr_en;
  logic                   start;

  assign busy     = (state_q != reg_pkg::CPY_IDLE);
  assign word_off = {idx_q[`EXT_ADDR_W-3:0], 2'b00};

  // Register read mux and decode, single-cycle response
  always_comb begin
    reg_hit         = 1'b1;
    reg_rsp_o.rdata = '0;
    case (reg_req_i.addr)
      reg_pkg::REG_SRC:    reg_rsp_o.rdata = src_q;
      reg_pkg::REG_DST:    reg_rsp_o.rdata = dst_q;
      reg_pkg::REG_SIZE:   reg_rsp_o.rdata = size_q;
      reg_pkg::REG_CTRL:   reg_rsp_o.rdata = '0;
      reg_pkg::REG_STATUS: reg_rsp_o.rdata = {{(`EXT_DATA_W-2){1'b0}}, done_q, busy};
      default:             reg_hit = 1'b0;
    endcase
    reg_rsp_o.ready = reg_req_i.valid;
    // STATUS is read-only
    reg_rsp_o.error = reg_req_i.valid &&
                      (!reg_hit || (reg_req_i.write && reg_req_i.addr == reg_pkg::REG_STATUS));
  end

  assign wr_en = reg_req_i.valid && reg_req_i.write && !reg_rsp_o.error;
  assign start = wr_en && (reg_req_i.addr == reg_pkg::REG_CTRL) && reg_req_i.wdata[0] && !busy;

  // Configuration registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      size_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        reg_pkg::REG_SRC:  src_q <= reg_req_i.wdata;
        reg_pkg::REG_DST:  dst_q <= reg_req_i.wdata;
        reg_pkg::REG_SIZE: size_q <= reg_req_i.wdata;
        default: ;
      endcase
    end
  end

  // Copy FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= reg_pkg::CPY_IDLE;
      idx_q   <= '0;
      done_q  <= 1'b0;
      intr_q  <= 1'b0;
    end else begin
      intr_q <= 1'b0;
      case (state_q)
        reg_pkg::CPY_IDLE: begin
          if (start) begin
            state_q <= reg_pkg::CPY_RD_REQ;
            idx_q   <= '0;
            done_q  <= 1'b0;
          end
        end
        reg_pkg::CPY_RD_REQ: begin
          if (size_q == '0) begin
            // Empty copy, finish without touching memory
            state_q <= reg_pkg::CPY_IDLE;
            done_q  <= 1'b1;
            intr_q  <= 1'b1;
          end else if (master_resp_i.gnt) begin
            state_q <= reg_pkg::CPY_RD_WAIT;
          end
        end
        reg_pkg::CPY_RD_WAIT: begin
          if (master_resp_i.rvalid) begin
            state_q <= reg_pkg::CPY_WR_REQ;
          end
        end
        reg_pkg::CPY_WR_REQ: begin
          if (master_resp_i.gnt) begin
            state_q <= reg_pkg::CPY_WR_WAIT;
          end
        end
        reg_pkg::CPY_WR_WAIT: begin
          if (master_resp_i.rvalid) begin
            if (idx_q == size_q - 1'b1) begin
              state_q <= reg_pkg::CPY_IDLE;
              done_q  <= 1'b1;
              intr_q  <= 1'b1;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= reg_pkg::CPY_RD_REQ;
            end
          end
        end
        default: state_q <= reg_pkg::CPY_IDLE;
      endcase
    end
  end

  // Word in transit between the read and the write
  always_ff @(posedge clk_i) begin
    if (state_q == reg_pkg::CPY_RD_WAIT && master_resp_i.rvalid) begin
      data_q <= master_resp_i.rdata;
    end
  end

  // Master port, request held until gnt by staying in the REQ state
  always_comb begin
    master_req_o = '0;
    case (state_q)
      reg_pkg::CPY_RD_REQ: begin
        master_req_o.req  = (size_q != '0);
        master_req_o.addr = src_q + word_off;
      end
      reg_pkg::CPY_WR_REQ: begin
        master_req_o.req   = 1'b1;
        master_req_o.we    = 1'b1;
        master_req_o.addr  = dst_q + word_off;
        master_req_o.wdata = data_q;
      end
      default: ;
    endcase
  end

  assign copy_intr_o = intr_q;

endmodule

`default_nettype wire

//--- verilog/obi_arbiter.sv
/*
 * Two-master round-robin arbiter in front of a single memory port.
 * Ownership lasts from the grant to the matching rvalid, no added cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module obi_arbiter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  host_req_i,
  output obi_pkg::obi_resp_t host_resp_o,
  input  obi_pkg::obi_req_t  copy_req_i,
  output obi_pkg::obi_resp_t copy_resp_o,
  output obi_pkg::obi_req_t  mem_req_o,
  input  obi_pkg::obi_resp_t mem_resp_i
);

  obi_pkg::obi_owner_e owner_q;
  obi_pkg::obi_owner_e sel_owner;
  logic                last_host_q;

  // Pick a requester only while the memory has no transaction in flight
  always_comb begin
    sel_owner = obi_pkg::OWNER_NONE;
    if (owner_q == obi_pkg::OWNER_NONE) begin
      if (host_req_i.req && copy_req_i.req) begin
        // Tie goes to whoever lost last time
        sel_owner = last_host_q ? obi_pkg::OWNER_COPY : obi_pkg::OWNER_HOST;
      end else if (host_req_i.req) begin
        sel_owner = obi_pkg::OWNER_HOST;
      end else if (copy_req_i.req) begin
        sel_owner = obi_pkg::OWNER_COPY;
      end
    end
  end

  // Request forward and response routing
  always_comb begin
    mem_req_o   = '0;
    host_resp_o = '0;
    copy_resp_o = '0;

    case (sel_owner)
      obi_pkg::OWNER_HOST: begin
        mem_req_o       = host_req_i;
        host_resp_o.gnt = mem_resp_i.gnt;
      end
      obi_pkg::OWNER_COPY: begin
        mem_req_o       = copy_req_i;
        copy_resp_o.gnt = mem_resp_i.gnt;
      end
      default: ;
    endcase

    case (owner_q)
      obi_pkg::OWNER_HOST: begin
        host_resp_o.rvalid = mem_resp_i.rvalid;
        host_resp_o.rdata  = mem_resp_i.rdata;
      end
      obi_pkg::OWNER_COPY: begin
        copy_resp_o.rvalid = mem_resp_i.rvalid;
        copy_resp_o.rdata  = mem_resp_i.rdata;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q     <= obi_pkg::OWNER_NONE;
      last_host_q <= 1'b0;
    end else if (mem_resp_i.rvalid) begin
      owner_q <= obi_pkg::OWNER_NONE;
    end else if (mem_resp_i.gnt) begin
      owner_q     <= sel_owner;
      last_host_q <= (sel_owner == obi_pkg::OWNER_HOST);
    end
  end

endmodule

`default_nettype wire

//--- verilog/obi_pkg.sv
/*
 * Types of the word memory bus (OBI style, req/gnt then rvalid).
 * Shared by the host port, the copier master, the arbiter and the memory.
 */
`default_nettype none

`include "ext_macros.svh"

package obi_pkg;

  // Address phase, fields held stable until gnt
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`EXT_ADDR_W-1:0] addr;
    logic [`EXT_DATA_W-1:0] wdata;
  } obi_req_t;

  // Grant plus the single response beat
  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [`EXT_DATA_W-1:0] rdata;
  } obi_resp_t;

  // Master that currently owns the shared memory
  typedef enum logic [1:0] {
    OWNER_NONE = 2'd0,
    OWNER_HOST = 2'd1,
    OWNER_COPY = 2'd2
  } obi_owner_e;

endpackage

`default_nettype wire

//--- verilog/reg_pkg.sv
/*
 * Types of the valid/ready register bus and of the memory-copy peripheral:
 * request and response structs, register offsets and copier states.
 */
`default_nettype none

`include "ext_macros.svh"

package reg_pkg;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [7:0]             addr;
    logic [`EXT_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                   ready;
    logic                   error;
    logic [`EXT_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Copier register offsets
  typedef enum logic [7:0] {
    REG_SRC    = 8'h00,
    REG_DST    = 8'h04,
    REG_SIZE   = 8'h08,
    REG_CTRL   = 8'h0C,  // bit 0 starts a copy
    REG_STATUS = 8'h10   // bit 0 busy, bit 1 done
  } reg_addr_e;

  // One read then one write per word
  typedef enum logic [2:0] {
    CPY_IDLE    = 3'd0,
    CPY_RD_REQ  = 3'd1,
    CPY_RD_WAIT = 3'd2,
    CPY_WR_REQ  = 3'd3,
    CPY_WR_WAIT = 3'd4
  } copy_state_e;

endpackage

`default_nettype wire

//--- verilog/slow_memory.sv
/*
 * Word memory behind the arbiter. Accepts one request at a time and answers
 * each grant with a single rvalid after a fixed number of cycles.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ext_macros.svh"

module slow_memory (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  mem_req_i,
  output obi_pkg::obi_resp_t mem_resp_o
);

  localparam int IDX_W = $clog2(`EXT_MEM_WORDS);
  localparam int CNT_W = $clog2(`EXT_MEM_LATENCY + 1);

  logic [`EXT_DATA_W-1:0] mem_q [`EXT_MEM_WORDS];
  logic [IDX_W-1:0]       word_idx;
  logic [CNT_W-1:0]       lat_cnt_q;
  logic [`EXT_DATA_W-1:0] rdata_q;
  logic                   gnt;

  // Word part of the byte address
  assign word_idx = mem_req_i.addr[IDX_W+1:2];

  // Only idle memory can accept
  assign gnt = mem_req_i.req && (lat_cnt_q == '0);

  // Latency counter, loaded at the grant edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lat_cnt_q <= '0;
    end else if (gnt) begin
      lat_cnt_q <= CNT_W'(`EXT_MEM_LATENCY);
    end else if (lat_cnt_q != '0) begin
      lat_cnt_q <= lat_cnt_q - 1'b1;
    end
  end

  // Array access happens at the grant, result waits for the counter
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (mem_req_i.we) begin
        mem_q[word_idx] <= mem_req_i.wdata;
      end
      rdata_q <= mem_q[word_idx];
    end
  end

  // Counter reaches 1 exactly latency cycles after the grant cycle
  always_comb begin
    mem_resp_o.gnt    = gnt;
    mem_resp_o.rvalid = (lat_cnt_q == CNT_W'(1));
    mem_resp_o.rdata  = rdata_q;
  end

endmodule

`default_nettype wire
